// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -j 0
TOP       := tb_bp_frontend
FILELIST  := filelist.f
OBJ_DIR   := obj_dir
SIM_BIN   := $(OBJ_DIR)/V$(TOP)
SOURCES   := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: $(SIM_BIN)
	@out="$$(./$(SIM_BIN))"; echo "$$out"; echo "$$out" | grep -qx "Test OK"

clean:
	rm -rf $(OBJ_DIR)

// ==== dv/tb_bp_frontend.sv ====
/*
 * Directed testbench of the fetch address generator. Plays the fetch
 * source and the branch unit and checks the registered fetch address.
 */
`timescale 1ns/1ps

module tb_bp_frontend;
	import bp_pkg::*;

	localparam int     CYCLE_LIMIT = 2000;
	localparam instr_t NOP         = 32'h0000_0013;    // addi x0, x0, 0
	localparam instr_t C_NOP       = 32'h0000_0001;

	logic   CLK;
	logic   arst_n;
	logic   is_reset;
	instr_t instr;
	addr_t  fetch_pc;
	logic   fetch_pc_valid;
	logic   exception;
	addr_t  exception_pc;
	logic   jalr_valid;
	addr_t  jalr_pc;
	logic   bru_res_valid;
	logic   bru_taken_branch;
	logic   mispredict;
	addr_t  fetch_addr;
	logic   fetch_addr_valid;

	logic [31:0] lfsr;
	int          cycles;

	bp_frontend_top u_bp_frontend_top (.*);

	always #4 CLK = ~CLK;

	always @(posedge CLK) begin
		cycles <= cycles + 1;
		if (cycles == CYCLE_LIMIT) begin
			$display("Timeout after %0d cycles, the run did not finish", cycles);
			$display("Test FAILED");
			$fatal(1, "Cycle limit reached");
		end
	end

	// Galois LFSR stepped once for each bit handed out
	function automatic logic [63:0] rand_bits(input int n);
		logic [63:0] r;
		logic        lsb;
		r = '0;
		for (int i = 0; i < n; i++) begin
			lsb  = lfsr[0];
			lfsr = lfsr >> 1;
			if (lsb)
				lfsr = lfsr ^ 32'hA300_0000;
			r = {r[62:0], lsb};
		end
		return r;
	endfunction

	function automatic addr_t rand_pc();
		return RESET_PC + (rand_bits(16) << 2);    // Word aligned
	endfunction

	function automatic instr_t enc_jal(input logic [4:0] rd, input logic [20:0] off);
		return {off[20], off[10:1], off[11], off[19:12], rd, OPC_JAL};
	endfunction

	// BEQ x0, x0 with the given offset
	function automatic instr_t enc_branch(input logic [12:0] off);
		return {off[12], off[10:5], 5'd0, 5'd0, 3'b000, off[4:1], off[11], OPC_BRANCH};
	endfunction

	function automatic instr_t enc_jalr(input logic [4:0] rd, input logic [4:0] rs1);
		return {12'd0, rs1, 3'b000, rd, OPC_JALR};
	endfunction

	task automatic check_addr(input string name, input addr_t exp, input addr_t act);
		if (act !== exp) begin
			$display("MISMATCH %s expected %h actual %h", name, exp, act);
			$display("Test FAILED");
			$fatal(1, "Address check failed");
		end
	endtask

	task automatic check_bit(input string name, input logic exp, input logic act);
		if (act !== exp) begin
			$display("MISMATCH %s expected %b actual %b", name, exp, act);
			$display("Test FAILED");
			$fatal(1, "Flag check failed");
		end
	endtask

	// One fetch cycle, then sample the registered result
	task automatic do_fetch(input instr_t word, input addr_t pc, input logic jv,
			input addr_t jpc);
		@(posedge CLK);
		instr          <= word;
		fetch_pc       <= pc;
		fetch_pc_valid <= 1'b1;
		jalr_valid     <= jv;
		jalr_pc        <= jpc;
		@(posedge CLK);
		fetch_pc_valid <= 1'b0;
		jalr_valid     <= 1'b0;
		@(negedge CLK);
	endtask

	task automatic fetch_expect(input string name, input instr_t word, input addr_t pc,
			input addr_t exp);
		do_fetch(word, pc, 1'b0, '0);
		check_addr(name, exp, fetch_addr);
		check_bit(name, 1'b1, fetch_addr_valid);
	endtask

	task automatic raise_exception(input string name, input addr_t epc);
		@(posedge CLK);
		exception    <= 1'b1;
		exception_pc <= epc;
		@(posedge CLK);
		exception <= 1'b0;
		@(negedge CLK);
		check_addr(name, epc, fetch_addr);
		check_bit(name, 1'b1, fetch_addr_valid);
	endtask

	// Mispredict is checked in the resolving cycle, the redirect one cycle later
	task automatic resolve_wrong(input string name, input logic taken, input addr_t exp);
		@(posedge CLK);
		bru_res_valid    <= 1'b1;
		bru_taken_branch <= taken;
		@(negedge CLK);
		check_bit(name, 1'b1, mispredict);
		@(posedge CLK);
		bru_res_valid <= 1'b0;
		@(negedge CLK);
		check_addr(name, exp, fetch_addr);
		check_bit(name, 1'b1, fetch_addr_valid);
	endtask

	task automatic test_reset();
		addr_t pc;
		check_addr("reset", RESET_PC, fetch_addr);
		check_bit("reset", 1'b0, fetch_addr_valid);
		pc = rand_pc();
		fetch_expect("reset_fetch", NOP, pc, pc + 64'd4);
		@(posedge CLK);
		is_reset <= 1'b1;
		@(posedge CLK);
		is_reset <= 1'b0;
		@(negedge CLK);
		check_addr("is_reset", RESET_PC, fetch_addr);
		check_bit("is_reset", 1'b0, fetch_addr_valid);
	endtask

	task automatic test_static();
		addr_t pc;
		imm_t  off;
		for (int i = 0; i < 4; i++) begin
			pc = rand_pc();
			fetch_expect("static_plain", NOP, pc, pc + 64'd4);
			fetch_expect("static_rvc", C_NOP, pc, pc + 64'd2);
			off = -((rand_bits(9) << 2) + 64'd4);
			fetch_expect("static_back_branch", enc_branch(off[12:0]), pc, pc + off);
			off = (rand_bits(9) << 2) + 64'd4;    // Forward, so not taken
			fetch_expect("static_fwd_branch", enc_branch(off[12:0]), pc, pc + 64'd4);
			off = (rand_bits(18) << 2) - 64'h8_0000;
			fetch_expect("static_jal", enc_jal(5'd0, off[20:0]), pc, pc + off);
		end
	endtask

	task automatic test_call_return();
		addr_t pc;
		addr_t ret_pc;
		addr_t tgt;
		imm_t  off;
		pc     = rand_pc();
		off    = (rand_bits(12) << 2) + 64'd8;
		ret_pc = pc + 64'd4;
		fetch_expect("call", enc_jal(REG_RA, off[20:0]), pc, pc + off);
		fetch_expect("return", enc_jalr(5'd0, REG_RA), pc + off, ret_pc);
		// Stack is empty again, so the jump waits for the register value
		do_fetch(enc_jalr(5'd0, REG_RA), ret_pc, 1'b0, '0);
		check_bit("jalr_stall", 1'b0, fetch_addr_valid);
		tgt = rand_pc();
		do_fetch(enc_jalr(5'd0, REG_RA), ret_pc, 1'b1, tgt);
		check_addr("jalr_resolved", tgt, fetch_addr);
		check_bit("jalr_resolved", 1'b1, fetch_addr_valid);
	endtask

	task automatic test_mispredict();
		addr_t pc_f;
		addr_t pc_b;
		imm_t  off_f;
		imm_t  off_b;
		raise_exception("flush_before_resolve", rand_pc());    // Drops branches left over
		pc_f  = rand_pc();
		off_f = (rand_bits(9) << 2) + 64'd4;
		pc_b  = rand_pc();
		off_b = -((rand_bits(9) << 2) + 64'd4);
		fetch_expect("queue_fwd", enc_branch(off_f[12:0]), pc_f, pc_f + 64'd4);
		fetch_expect("queue_back", enc_branch(off_b[12:0]), pc_b, pc_b + off_b);
		resolve_wrong("resolve_fwd", 1'b1, pc_f + off_f);
		// The redirect flushed the backward branch, so no head is left to disagree with
		@(posedge CLK);
		bru_res_valid    <= 1'b1;
		bru_taken_branch <= 1'b0;
		@(negedge CLK);
		check_bit("mispredict_flush", 1'b0, mispredict);
		@(posedge CLK);
		bru_res_valid <= 1'b0;
		@(negedge CLK);
		fetch_expect("requeue_back", enc_branch(off_b[12:0]), pc_b, pc_b + off_b);
		resolve_wrong("resolve_back", 1'b0, pc_b + 64'd4);
	endtask

	task automatic test_queue_full();
		addr_t pc;
		imm_t  off;
		pc  = rand_pc();
		off = (rand_bits(9) << 2) + 64'd4;
		for (int i = 0; i < BQ_DEPTH; i++)
			fetch_expect("fill_queue", enc_branch(off[12:0]), pc, pc + 64'd4);
		do_fetch(enc_branch(off[12:0]), pc, 1'b0, '0);
		check_bit("queue_full_stall", 1'b0, fetch_addr_valid);
		raise_exception("exception_flush", rand_pc());
		fetch_expect("after_flush", enc_branch(off[12:0]), pc, pc + 64'd4);
	endtask

	initial begin
		CLK              = 1'b0;
		arst_n           = 1'b0;
		is_reset         = 1'b0;
		instr            = '0;
		fetch_pc         = '0;
		fetch_pc_valid   = 1'b0;
		exception        = 1'b0;
		exception_pc     = '0;
		jalr_valid       = 1'b0;
		jalr_pc          = '0;
		bru_res_valid    = 1'b0;
		bru_taken_branch = 1'b0;
		lfsr             = 32'd77;
		cycles           = 0;
		repeat (5) @(posedge CLK);
		arst_n <= 1'b1;
		@(negedge CLK);
		test_reset();
		test_static();
		test_call_return();
		test_mispredict();
		test_queue_full();
		$display("Test OK");
		$finish;
	end

endmodule

// ==== filelist.f ====
src/bp_pkg.sv
src/bp_decode_if.sv
src/bp_predecode.sv
src/bp_branch_queue.sv
src/bp_return_stack.sv
src/branch_predict.sv
src/bp_frontend_top.sv
dv/tb_bp_frontend.sv

// ==== src/bp_branch_queue.sv ====
/*
 * Flushable FIFO of pending branch predictions and their alternative addresses.
 */
`timescale 1ns/1ps

module bp_branch_queue (
	input  logic              CLK,
	input  logic              arst_n,
	input  logic              push,
	input  logic              pop,
	input  logic              flush,
	input  bp_pkg::bq_entry_t data_push,
	output bp_pkg::bq_entry_t data_pop,
	output logic              full,
	output logic              empty
);
	import bp_pkg::*;

	bq_entry_t mem [BQ_DEPTH];

	// Top bit of each pointer tells a full ring from an empty one
	logic [BQ_AW:0] wr_ptr;
	logic [BQ_AW:0] rd_ptr;
	logic           do_push;
	logic           do_pop;

	assign empty = (wr_ptr == rd_ptr);
	assign full  = (wr_ptr[BQ_AW] != rd_ptr[BQ_AW]) &&
		(wr_ptr[BQ_AW-1:0] == rd_ptr[BQ_AW-1:0]);

	assign do_push = push & ~full & ~flush;
	assign do_pop  = pop & ~empty & ~flush;

	assign data_pop = mem[rd_ptr[BQ_AW-1:0]];    // Head entry is always visible

	always_ff @(posedge CLK or negedge arst_n) begin
		if (!arst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
		end else if (flush) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
		end else begin
			if (do_push)
				wr_ptr <= wr_ptr + 1'b1;
			if (do_pop)
				rd_ptr <= rd_ptr + 1'b1;
		end
	end

	always_ff @(posedge CLK) begin
		if (do_push)
			mem[wr_ptr[BQ_AW-1:0]] <= data_push;
	end

endmodule

// ==== src/bp_decode_if.sv ====
/*
 * Predecode results passed from the predecoder to the predictor.
 */
`timescale 1ns/1ps

interface bp_decode_if;
	import bp_pkg::*;

	logic is_jal;      // Direct jump, JAL or C.J
	logic is_jalr;     // Register jump, JALR, C.JR or C.JALR
	logic is_branch;
	logic is_call;
	logic is_return;
	logic is_rvc;      // Compressed 16-bit word
	imm_t imm;

	modport producer (
		output is_jal, is_jalr, is_branch, is_call, is_return, is_rvc, imm
	);

	modport consumer (
		input is_jal, is_jalr, is_branch, is_call, is_return, is_rvc, imm
	);

endinterface

// ==== src/bp_frontend_top.sv ====
/*
 * Fetch address generator top. Joins the predecoder and the predictor.
 */
`timescale 1ns/1ps

module bp_frontend_top (
	input  logic           CLK,
	input  logic           arst_n,
	input  logic           is_reset,
	input  bp_pkg::instr_t instr,
	input  bp_pkg::addr_t  fetch_pc,
	input  logic           fetch_pc_valid,
	input  logic           exception,
	input  bp_pkg::addr_t  exception_pc,
	input  logic           jalr_valid,
	input  bp_pkg::addr_t  jalr_pc,
	input  logic           bru_res_valid,
	input  logic           bru_taken_branch,
	output logic           mispredict,
	output bp_pkg::addr_t  fetch_addr,
	output logic           fetch_addr_valid
);

	bp_decode_if u_decode_if ();

	bp_predecode u_predecode (
		.instr (instr),
		.dec   (u_decode_if.producer)
	);

	branch_predict u_branch_predict (
		.CLK              (CLK),
		.arst_n           (arst_n),
		.is_reset         (is_reset),
		.dec              (u_decode_if.consumer),
		.fetch_pc         (fetch_pc),
		.fetch_pc_valid   (fetch_pc_valid),
		.exception        (exception),
		.exception_pc     (exception_pc),
		.jalr_valid       (jalr_valid),
		.jalr_pc          (jalr_pc),
		.bru_res_valid    (bru_res_valid),
		.bru_taken_branch (bru_taken_branch),
		.mispredict       (mispredict),
		.fetch_addr       (fetch_addr),
		.fetch_addr_valid (fetch_addr_valid)
	);

endmodule

// ==== src/bp_pkg.sv ====
/*
 * Shared types and constants of the fetch address generator.
 * Covers address, instruction and immediate widths, queue and stack depths.
 */
package bp_pkg;

	typedef logic [63:0] addr_t;     // Instruction address
	typedef logic [63:0] imm_t;      // Sign-extended immediate offset
	typedef logic [31:0] instr_t;    // Fetched instruction word

	// Predicted-taken bit on top of the alternative address
	typedef logic [64:0] bq_entry_t;

	localparam int BQ_DEPTH  = 16;
	localparam int BQ_AW     = $clog2(BQ_DEPTH);
	localparam int RAS_DEPTH = 16;
	localparam int RAS_AW    = $clog2(RAS_DEPTH);

	// Position of the predicted-taken flag inside a queue entry
	localparam int BQ_TAKEN_BIT = 64;

	localparam addr_t RESET_PC = 64'h0000_0000_8000_0000;

	// Major opcodes of the 32-bit control transfer instructions
	localparam logic [6:0] OPC_JAL    = 7'b1101111;
	localparam logic [6:0] OPC_JALR   = 7'b1100111;
	localparam logic [6:0] OPC_BRANCH = 7'b1100011;

	// Link registers recognized by the call and return hints
	localparam logic [4:0] REG_RA = 5'd1;
	localparam logic [4:0] REG_T0 = 5'd5;

endpackage

// ==== src/bp_predecode.sv ====
/*
 * Instruction predecoder. Classifies a fetched word as branch, jump, call
 * or return and reassembles its sign-extended immediate.
 */
`timescale 1ns/1ps

module bp_predecode (
	input  bp_pkg::instr_t instr,
	bp_decode_if.producer  dec
);
	import bp_pkg::*;

	logic       jal;
	logic       jalr;
	logic       branch;
	logic [4:0] rd;
	logic [4:0] rs1;
	imm_t       imm_val;

	function automatic logic is_link(input logic [4:0] r);
		return (r == REG_RA) || (r == REG_T0);
	endfunction

	always_comb begin
		jal     = 1'b0;
		jalr    = 1'b0;
		branch  = 1'b0;
		rd      = instr[11:7];
		rs1     = instr[19:15];
		imm_val = '0;

		if (instr[1:0] == 2'b11) begin
			unique case (instr[6:0])
				OPC_JAL: begin
					jal     = 1'b1;
					imm_val = {{43{instr[31]}}, instr[31], instr[19:12], instr[20],
						instr[30:21], 1'b0};
				end
				OPC_JALR: begin
					jalr    = (instr[14:12] == 3'b000);
					imm_val = {{52{instr[31]}}, instr[31:20]};
				end
				OPC_BRANCH: begin
					branch  = (instr[14:13] != 2'b01);    // funct3 010 and 011 are reserved
					imm_val = {{51{instr[31]}}, instr[31], instr[7], instr[30:25],
						instr[11:8], 1'b0};
				end
				default: ;
			endcase
		end else if (instr[1:0] == 2'b01) begin
			// Quadrant 1 holds C.J, C.BEQZ and C.BNEZ
			unique case (instr[15:13])
				3'b101: begin
					jal     = 1'b1;
					rd      = 5'd0;
					imm_val = {{52{instr[12]}}, instr[12], instr[8], instr[10:9], instr[6],
						instr[7], instr[2], instr[11], instr[5:3], 1'b0};
				end
				3'b110, 3'b111: begin
					branch  = 1'b1;
					rd      = 5'd0;
					imm_val = {{55{instr[12]}}, instr[12], instr[6:5], instr[2],
						instr[11:10], instr[4:3], 1'b0};
				end
				default: ;
			endcase
		end else if (instr[1:0] == 2'b10 && instr[15:13] == 3'b100 &&
				instr[11:7] != 5'd0 && instr[6:2] == 5'd0) begin
			// C.JR links nothing, C.JALR writes ra
			jalr = 1'b1;
			rs1  = instr[11:7];
			rd   = instr[12] ? REG_RA : 5'd0;
		end
	end

	assign dec.is_jal    = jal;
	assign dec.is_jalr   = jalr;
	assign dec.is_branch = branch;
	assign dec.is_rvc    = (instr[1:0] != 2'b11);
	assign dec.imm       = imm_val;

	// A jump writing a link register is a call
	assign dec.is_call   = (jal | jalr) & is_link(rd);
	assign dec.is_return = jalr & is_link(rs1) & ~is_link(rd);

endmodule

// ==== src/bp_return_stack.sv ====
/*
 * Return address stack kept as a ring. A push on a full ring drops the
 * oldest address, and flush empties it.
 */
`timescale 1ns/1ps

module bp_return_stack (
	input  logic          CLK,
	input  logic          arst_n,
	input  logic          push,
	input  logic          pop,
	input  logic          flush,
	input  bp_pkg::addr_t data_push,
	output bp_pkg::addr_t data_pop,
	output logic          empty
);
	import bp_pkg::*;

	addr_t mem [RAS_DEPTH];

	logic [RAS_AW-1:0] top;      // Index of the most recent entry
	logic [RAS_AW:0]   count;    // Live entries, saturates at RAS_DEPTH
	logic [RAS_AW-1:0] wr_idx;
	logic              do_push;
	logic              do_pop;

	assign empty    = (count == '0);
	assign data_pop = mem[top];

	assign do_push = push & ~flush;
	assign do_pop  = pop & ~empty & ~flush;

	// Push with pop rewrites the top slot in place
	assign wr_idx = do_pop ? top : top + 1'b1;

	always_ff @(posedge CLK or negedge arst_n) begin
		if (!arst_n) begin
			top   <= '0;
			count <= '0;
		end else if (flush) begin
			count <= '0;
		end else if (do_push && !do_pop) begin
			top <= top + 1'b1;
			if (count != RAS_DEPTH[RAS_AW:0])
				count <= count + 1'b1;
		end else if (do_pop && !do_push) begin
			top   <= top - 1'b1;
			count <= count - 1'b1;
		end
	end

	always_ff @(posedge CLK) begin
		if (do_push)
			mem[wr_idx] <= data_push;
	end

endmodule

// ==== src/branch_predict.sv ====
/*
 * Static branch predictor and fetch address register. Picks the next fetch
 * address from predecode, the return stack and branch resolutions.
 */
`timescale 1ns/1ps

module branch_predict (
	input  logic          CLK,
	input  logic          arst_n,
	input  logic          is_reset,
	bp_decode_if.consumer dec,
	input  bp_pkg::addr_t fetch_pc,
	input  logic          fetch_pc_valid,
	input  logic          exception,
	input  bp_pkg::addr_t exception_pc,
	input  logic          jalr_valid,
	input  bp_pkg::addr_t jalr_pc,
	input  logic          bru_res_valid,
	input  logic          bru_taken_branch,
	output logic          mispredict,
	output bp_pkg::addr_t fetch_addr,
	output logic          fetch_addr_valid
);
	import bp_pkg::*;

	addr_t     next_pc;
	addr_t     take_pc;
	addr_t     resolve_pc;
	addr_t     fetch_addr_dnxt;
	logic      fetch_addr_valid_dnxt;
	logic      fetch_addr_load;

	logic      predict_taken;
	logic      bq_stall;
	logic      jalr_stall;
	logic      fetch_accept;
	logic      flush;

	bq_entry_t bq_data_push;
	bq_entry_t bq_data_pop;
	logic      bq_push;
	logic      bq_full;
	logic      bq_empty;

	addr_t     ras_data_pop;
	logic      ras_push;
	logic      ras_pop;
	logic      ras_empty;

	// Backward branches and every jump go the taken way
	assign predict_taken = (dec.is_branch & dec.imm[63]) | dec.is_jal | dec.is_jalr;

	assign bq_stall   = dec.is_branch & bq_full;
	// A return can still go ahead on the stack's word alone
	assign jalr_stall = dec.is_jalr & ~jalr_valid & (ras_empty | ~dec.is_return);

	assign fetch_accept = fetch_pc_valid & ~bq_stall & ~jalr_stall;

	// Resolutions arrive in program order and match the queue head
	assign mispredict = bru_res_valid & ~bq_empty &
		(bru_taken_branch ^ bq_data_pop[BQ_TAKEN_BIT]);
	assign resolve_pc = bq_data_pop[63:0];
	assign flush      = mispredict | exception;

	assign ras_push = fetch_accept & dec.is_call;
	assign ras_pop  = fetch_accept & dec.is_jalr & dec.is_return & ~ras_empty;

	assign next_pc = fetch_pc + (dec.is_rvc ? 64'd2 : 64'd4);

	always_comb begin
		if (dec.is_jalr)
			take_pc = ras_pop ? ras_data_pop : jalr_pc;
		else
			take_pc = fetch_pc + dec.imm;    // Branches and JAL are PC relative
	end

	// Keep the way not chosen so a mispredict can go back to it
	assign bq_push      = fetch_accept & dec.is_branch;
	assign bq_data_push = {predict_taken, predict_taken ? next_pc : take_pc};

	always_comb begin
		if (is_reset)
			fetch_addr_dnxt = RESET_PC;
		else if (exception)
			fetch_addr_dnxt = exception_pc;
		else if (mispredict)
			fetch_addr_dnxt = resolve_pc;
		else if (fetch_accept)
			fetch_addr_dnxt = predict_taken ? take_pc : next_pc;
		else
			fetch_addr_dnxt = fetch_pc;
	end

	assign fetch_addr_valid_dnxt = fetch_accept | mispredict | exception;
	assign fetch_addr_load       = fetch_pc_valid | mispredict | exception | is_reset;

	always_ff @(posedge CLK or negedge arst_n) begin
		if (!arst_n) begin
			fetch_addr       <= RESET_PC;
			fetch_addr_valid <= 1'b0;
		end else begin
			fetch_addr_valid <= fetch_addr_valid_dnxt;
			if (fetch_addr_load)
				fetch_addr <= fetch_addr_dnxt;
		end
	end

	bp_branch_queue u_branch_queue (
		.CLK       (CLK),
		.arst_n    (arst_n),
		.push      (bq_push),
		.pop       (bru_res_valid),
		.flush     (flush),
		.data_push (bq_data_push),
		.data_pop  (bq_data_pop),
		.full      (bq_full),
		.empty     (bq_empty)
	);

	bp_return_stack u_return_stack (
		.CLK       (CLK),
		.arst_n    (arst_n),
		.push      (ras_push),
		.pop       (ras_pop),
		.flush     (flush),
		.data_push (next_pc),    // Return lands right after the call
		.data_pop  (ras_data_pop),
		.empty     (ras_empty)
	);

endmodule
